/* src/cache_pkg.sv */
// Cache geometry: direct-mapped, 8 sets of 32-byte lines, and the address decode
`default_nettype none

package cache_pkg;

  localparam int SET_BITS  = 3;
  localparam int WORD_BITS = 3;   // Eight words per line
  localparam int BYTE_BITS = 2;
  localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - BYTE_BITS;

  localparam int NUM_SETS  = 1 << SET_BITS;
  localparam int LINE_BITS = 32 << WORD_BITS;

  // Field order follows the address from MSB down
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [SET_BITS-1:0]  set_idx;
    logic [WORD_BITS-1:0] word_idx;
    logic [BYTE_BITS-1:0] byte_idx;
  } addr_fields_t;

  // One address word, seen either flat or split into cache fields
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } addr_u;

endpackage

`default_nettype wire

/* src/access_pkg.sv */
// CPU access definitions: store widths and request credit count
`default_nettype none

package access_pkg;

  // Store width of a write request, ignored for loads
  typedef enum logic [1:0] {
    SW = 2'd0,  // Full word
    SH = 2'd1,  // Halfword at byte offset bit 1
    SB = 2'd2   // Single byte
  } store_size_e;

  // Queue depth, also the credits the CPU holds after reset
  localparam int REQ_CREDITS = 2;

endpackage

`default_nettype wire

/* src/dcache_req_queue.sv */
// Request queue: small circular FIFO for CPU requests, one credit back per pop
`timescale 1ns/10ps
`default_nettype none

module dcache_req_queue (
  input  wire                     cs,
  input  wire                     i_rst_n,
  input  wire                     i_req_valid,
  input  wire                     i_req_write,
  input  wire access_pkg::store_size_e i_req_size,
  input  wire [31:0]              i_req_addr,
  input  wire [31:0]              i_req_wdata,
  input  wire                     i_pop,
  output logic                    o_head_valid,
  output logic                    o_head_write,
  output access_pkg::store_size_e o_head_size,
  output logic [31:0]             o_head_addr,
  output logic [31:0]             o_head_wdata,
  output logic                    o_credit
);

  logic                    q_write [access_pkg::REQ_CREDITS];
  access_pkg::store_size_e q_size  [access_pkg::REQ_CREDITS];
  logic [31:0]             q_addr  [access_pkg::REQ_CREDITS];
  logic [31:0]             q_wdata [access_pkg::REQ_CREDITS];

  logic [$clog2(access_pkg::REQ_CREDITS)-1:0]   wr_ptr;
  logic [$clog2(access_pkg::REQ_CREDITS)-1:0]   rd_ptr;
  logic [$clog2(access_pkg::REQ_CREDITS+1)-1:0] count;
  logic                                         pop;

  assign o_head_valid = (count != '0);
  assign pop          = i_pop && o_head_valid;
  assign o_credit     = pop;  // Entry leaves, slot is free again

  assign o_head_write = q_write[rd_ptr];
  assign o_head_size  = q_size[rd_ptr];
  assign o_head_addr  = q_addr[rd_ptr];
  assign o_head_wdata = q_wdata[rd_ptr];

  always_ff @(posedge cs) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_req_valid) begin
        wr_ptr <= (wr_ptr == access_pkg::REQ_CREDITS - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == access_pkg::REQ_CREDITS - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Credits keep the CPU from pushing into a full queue
      case ({i_req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge cs) begin
    if (i_req_valid) begin
      q_write[wr_ptr] <= i_req_write;
      q_size[wr_ptr]  <= i_req_size;
      q_addr[wr_ptr]  <= i_req_addr;
      q_wdata[wr_ptr] <= i_req_wdata;
    end
  end

endmodule

`default_nettype wire

/* src/dcache_line_store.sv */
// Line store: tag, valid and line arrays with one registered read port
`timescale 1ns/10ps
`default_nettype none

module dcache_line_store (
  input  wire                              cs,
  input  wire                              i_rst_n,
  input  wire [cache_pkg::SET_BITS-1:0]    i_rd_set,
  input  wire                              i_wr_en,
  input  wire [cache_pkg::SET_BITS-1:0]    i_wr_set,
  input  wire [cache_pkg::TAG_BITS-1:0]    i_wr_tag,
  input  wire [cache_pkg::LINE_BITS-1:0]   i_wr_line,
  output logic [cache_pkg::TAG_BITS-1:0]   o_rd_tag,
  output logic                             o_rd_valid,
  output logic [cache_pkg::LINE_BITS-1:0]  o_rd_line
);

  logic [cache_pkg::TAG_BITS-1:0]  tag_mem  [cache_pkg::NUM_SETS];
  logic [cache_pkg::LINE_BITS-1:0] line_mem [cache_pkg::NUM_SETS];
  logic [cache_pkg::NUM_SETS-1:0]  valid;

  // Valid bits, all lines invalid out of reset
  always_ff @(posedge cs) begin
    if (!i_rst_n) begin
      valid      <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      if (i_wr_en) begin
        valid[i_wr_set] <= 1'b1;
      end
      o_rd_valid <= valid[i_rd_set];
    end
  end

  // Tag and data arrays
  always_ff @(posedge cs) begin
    if (i_wr_en) begin
      tag_mem[i_wr_set]  <= i_wr_tag;
      line_mem[i_wr_set] <= i_wr_line;  // Always a whole line
    end
    o_rd_tag  <= tag_mem[i_rd_set];
    o_rd_line <= line_mem[i_rd_set];
  end

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
// Cache controller: lookup, refill, store merge and line write-through
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
  input  wire                              cs,
  input  wire                              i_rst_n,
  input  wire                              i_head_valid,
  input  wire                              i_head_write,
  input  wire access_pkg::store_size_e     i_head_size,
  input  wire [31:0]                       i_head_addr,
  input  wire [31:0]                       i_head_wdata,
  input  wire [cache_pkg::TAG_BITS-1:0]    i_rd_tag,
  input  wire                              i_rd_valid,
  input  wire [cache_pkg::LINE_BITS-1:0]   i_rd_line,
  input  wire [cache_pkg::LINE_BITS-1:0]   i_mem_rdata,
  input  wire                              i_mem_ready,
  input  wire                              i_mem_done,
  output logic                             o_pop,
  output logic [cache_pkg::SET_BITS-1:0]   o_rd_set,
  output logic                             o_wr_en,
  output logic [cache_pkg::SET_BITS-1:0]   o_wr_set,
  output logic [cache_pkg::TAG_BITS-1:0]   o_wr_tag,
  output logic [cache_pkg::LINE_BITS-1:0]  o_wr_line,
  output logic [31:0]                      o_mem_addr,
  output logic                             o_mem_rd,
  output logic                             o_mem_wr,
  output logic [cache_pkg::LINE_BITS-1:0]  o_mem_wdata,
  output logic                             o_rsp_valid,
  output logic                             o_rsp_hit,
  output logic [31:0]                      o_rsp_rdata
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    MERGE,
    WRITE_THROUGH
  } state_e;

  state_e                          state;
  cache_pkg::addr_u                head_a;
  cache_pkg::addr_u                req_a;
  cache_pkg::addr_u                line_a;
  logic                            req_write;
  access_pkg::store_size_e         req_size;
  logic [31:0]                     req_wdata;
  logic [cache_pkg::LINE_BITS-1:0] line_q;     // Refilled line waiting for merge
  logic [cache_pkg::LINE_BITS-1:0] merge_src;
  logic [cache_pkg::LINE_BITS-1:0] merged;
  logic                            hit;

  // Lays the store bytes into the line at the request's byte offset
  function automatic logic [cache_pkg::LINE_BITS-1:0] merge_store(
    input logic [cache_pkg::LINE_BITS-1:0] line,
    input cache_pkg::addr_u                a,
    input access_pkg::store_size_e         size,
    input logic [31:0]                     wdata
  );
    logic [cache_pkg::LINE_BITS-1:0] res;
    res = line;
    case (size)
      access_pkg::SB: res[{a.fields.word_idx, a.fields.byte_idx} * 8 +: 8] = wdata[7:0];
      access_pkg::SH: begin
        res[{a.fields.word_idx, a.fields.byte_idx[1], 1'b0} * 8 +: 16] = wdata[15:0];
      end
      default: res[a.fields.word_idx * 32 +: 32] = wdata;
    endcase
    return res;
  endfunction

  assign head_a   = i_head_addr;
  assign o_pop    = (state == IDLE) && i_head_valid;
  assign o_rd_set = head_a.fields.set_idx;  // Read issued in the pop cycle

  assign hit = i_rd_valid && (i_rd_tag == req_a.fields.tag);

  always_comb begin
    line_a                 = req_a;
    line_a.fields.word_idx = '0;
    line_a.fields.byte_idx = '0;
  end

  assign merge_src = (state == MERGE) ? line_q : i_rd_line;
  assign merged    = merge_store(merge_src, req_a, req_size, req_wdata);

  // Line store update: store hit, load refill, or store after refill
  assign o_wr_en   = ((state == LOOKUP) && hit && req_write) ||
                     ((state == REFILL) && i_mem_ready && !req_write) ||
                     (state == MERGE);
  assign o_wr_set  = req_a.fields.set_idx;
  assign o_wr_tag  = req_a.fields.tag;
  assign o_wr_line = (state == REFILL) ? i_mem_rdata : merged;

  always_ff @(posedge cs) begin
    if (!i_rst_n) begin
      state       <= IDLE;
      o_mem_rd    <= 1'b0;
      o_mem_wr    <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (i_head_valid) state <= LOOKUP;
        end
        LOOKUP: begin
          if (!hit) begin
            o_mem_rd <= 1'b1;
            state    <= REFILL;
          end else if (req_write) begin
            o_mem_wr <= 1'b1;  // Merged line goes straight out
            state    <= WRITE_THROUGH;
          end else begin
            o_rsp_valid <= 1'b1;
            state       <= IDLE;
          end
        end
        REFILL: begin
          if (i_mem_ready) begin
            o_mem_rd <= 1'b0;
            if (req_write) begin
              state <= MERGE;
            end else begin
              o_rsp_valid <= 1'b1;
              state       <= IDLE;
            end
          end
        end
        MERGE: begin
          o_mem_wr <= 1'b1;
          state    <= WRITE_THROUGH;
        end
        WRITE_THROUGH: begin
          if (i_mem_done) begin
            o_mem_wr    <= 1'b0;
            o_rsp_valid <= 1'b1;
            state       <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request, memory and response payload
  always_ff @(posedge cs) begin
    if (o_pop) begin
      req_a.raw <= i_head_addr;
      req_write <= i_head_write;
      req_size  <= i_head_size;
      req_wdata <= i_head_wdata;
    end
    if (state == LOOKUP) begin
      o_mem_addr  <= line_a.raw;  // Same line for refill and write
      o_mem_wdata <= merged;
      o_rsp_hit   <= hit;         // Held through a store's write
      o_rsp_rdata <= req_write ? 32'd0 : i_rd_line[req_a.fields.word_idx * 32 +: 32];
    end
    if ((state == REFILL) && i_mem_ready) begin
      line_q <= i_mem_rdata;
      if (!req_write) o_rsp_rdata <= i_mem_rdata[req_a.fields.word_idx * 32 +: 32];
    end
    if (state == MERGE) begin
      o_mem_wdata <= merged;
    end
  end

endmodule

`default_nettype wire

/* src/dcache_top.sv */
// Data cache top: request queue, controller and line store on CPU and memory ports
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
  input  wire                             cs,
  input  wire                             i_rst_n,
  input  wire                             i_req_valid,
  input  wire                             i_req_write,
  input  wire access_pkg::store_size_e    i_req_size,
  input  wire [31:0]                      i_req_addr,
  input  wire [31:0]                      i_req_wdata,
  output wire                             o_credit,
  output wire                             o_rsp_valid,
  output wire                             o_rsp_hit,
  output wire [31:0]                      o_rsp_rdata,
  output wire [31:0]                      o_mem_addr,
  output wire                             o_mem_rd,
  output wire                             o_mem_wr,
  output wire [cache_pkg::LINE_BITS-1:0]  o_mem_wdata,
  input  wire [cache_pkg::LINE_BITS-1:0]  i_mem_rdata,
  input  wire                             i_mem_ready,
  input  wire                             i_mem_done
);

  // Queue head towards the controller
  wire                            head_valid;
  wire                            head_write;
  wire access_pkg::store_size_e   head_size;
  wire [31:0]                     head_addr;
  wire [31:0]                     head_wdata;
  wire                            pop;

  // Controller and line store
  wire [cache_pkg::SET_BITS-1:0]  rd_set;
  wire [cache_pkg::TAG_BITS-1:0]  rd_tag;
  wire                            rd_valid;
  wire [cache_pkg::LINE_BITS-1:0] rd_line;
  wire                            wr_en;
  wire [cache_pkg::SET_BITS-1:0]  wr_set;
  wire [cache_pkg::TAG_BITS-1:0]  wr_tag;
  wire [cache_pkg::LINE_BITS-1:0] wr_line;

  dcache_req_queue dcache_req_queue_inst (
    .cs           (cs),
    .i_rst_n      (i_rst_n),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_size   (i_req_size),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_pop        (pop),
    .o_head_valid (head_valid),
    .o_head_write (head_write),
    .o_head_size  (head_size),
    .o_head_addr  (head_addr),
    .o_head_wdata (head_wdata),
    .o_credit     (o_credit)
  );

  dcache_ctrl dcache_ctrl_inst (
    .cs           (cs),
    .i_rst_n      (i_rst_n),
    .i_head_valid (head_valid),
    .i_head_write (head_write),
    .i_head_size  (head_size),
    .i_head_addr  (head_addr),
    .i_head_wdata (head_wdata),
    .i_rd_tag     (rd_tag),
    .i_rd_valid   (rd_valid),
    .i_rd_line    (rd_line),
    .i_mem_rdata  (i_mem_rdata),
    .i_mem_ready  (i_mem_ready),
    .i_mem_done   (i_mem_done),
    .o_pop        (pop),
    .o_rd_set     (rd_set),
    .o_wr_en      (wr_en),
    .o_wr_set     (wr_set),
    .o_wr_tag     (wr_tag),
    .o_wr_line    (wr_line),
    .o_mem_addr   (o_mem_addr),
    .o_mem_rd     (o_mem_rd),
    .o_mem_wr     (o_mem_wr),
    .o_mem_wdata  (o_mem_wdata),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_hit    (o_rsp_hit),
    .o_rsp_rdata  (o_rsp_rdata)
  );

  dcache_line_store dcache_line_store_inst (
    .cs         (cs),
    .i_rst_n    (i_rst_n),
    .i_rd_set   (rd_set),
    .i_wr_en    (wr_en),
    .i_wr_set   (wr_set),
    .i_wr_tag   (wr_tag),
    .i_wr_line  (wr_line),
    .o_rd_tag   (rd_tag),
    .o_rd_valid (rd_valid),
    .o_rd_line  (rd_line)
  );

endmodule

`default_nettype wire

/* tests/dcache_checker.sv */
// Memory port protocol assertions, bound into the cache top
`timescale 1ns/10ps
`default_nettype none

module dcache_checker (
  input wire                            cs,
  input wire                            i_rst_n,
  input wire [31:0]                     o_mem_addr,
  input wire                            o_mem_rd,
  input wire                            o_mem_wr,
  input wire [cache_pkg::LINE_BITS-1:0] o_mem_wdata,
  input wire                            i_mem_ready,
  input wire                            i_mem_done
);

  rd_wr_exclusive: assert property (@(posedge cs) disable iff (!i_rst_n)
    !(o_mem_rd && o_mem_wr))
    else $error("Memory read and write requested in the same cycle");

  // Line-aligned memory address
  addr_aligned: assert property (@(posedge cs) disable iff (!i_rst_n)
    (o_mem_rd || o_mem_wr) |-> (o_mem_addr[4:0] == 5'd0))
    else $error("Memory address 0x%h is not line aligned", o_mem_addr);

  rd_held: assert property (@(posedge cs) disable iff (!i_rst_n)
    (o_mem_rd && !i_mem_ready) |=> (o_mem_rd && $stable(o_mem_addr)))
    else $error("Line read dropped or address changed before ready");

  wr_held: assert property (@(posedge cs) disable iff (!i_rst_n)
    (o_mem_wr && !i_mem_done) |=> (o_mem_wr && $stable(o_mem_wdata) && $stable(o_mem_addr)))
    else $error("Line write dropped or data changed before done");

endmodule

bind dcache_top dcache_checker dcache_checker_inst (
  .cs          (cs),
  .i_rst_n     (i_rst_n),
  .o_mem_addr  (o_mem_addr),
  .o_mem_rd    (o_mem_rd),
  .o_mem_wr    (o_mem_wr),
  .o_mem_wdata (o_mem_wdata),
  .i_mem_ready (i_mem_ready),
  .i_mem_done  (i_mem_done)
);

`default_nettype wire

/* tests/dcache_tb.sv */
// Data cache testbench: random loads and stores checked against a byte-level reference
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

  localparam int          NUM_REQS   = 400;
  localparam int          MAX_CYCLES = NUM_REQS * 40 + 4000;  // Worst case per request
  localparam int          MEM_BYTES  = 1024;                  // 32 lines, four per set
  localparam logic [31:0] BASE_ADDR  = 32'h0001_c000;
  localparam int          LB         = cache_pkg::LINE_BITS;

  logic                    cs;
  logic                    i_rst_n;
  logic                    i_req_valid;
  logic                    i_req_write;
  access_pkg::store_size_e i_req_size;
  logic [31:0]             i_req_addr;
  logic [31:0]             i_req_wdata;
  logic [LB-1:0]           i_mem_rdata;
  logic                    i_mem_ready;
  logic                    i_mem_done;
  wire                     o_credit;
  wire                     o_rsp_valid;
  wire                     o_rsp_hit;
  wire [31:0]              o_rsp_rdata;
  wire [31:0]              o_mem_addr;
  wire                     o_mem_rd;
  wire                     o_mem_wr;
  wire [LB-1:0]            o_mem_wdata;

  logic [7:0]                     ref_mem   [MEM_BYTES];  // Reference, updated at issue
  logic [7:0]                     model_mem [MEM_BYTES];  // Memory behind the DUT
  logic [cache_pkg::TAG_BITS-1:0] ref_tag   [cache_pkg::NUM_SETS];
  logic [cache_pkg::NUM_SETS-1:0] ref_valid;
  logic                           exp_hit[$];
  logic                           exp_write[$];
  logic                           exp_first[$];
  logic [31:0]                    exp_rdata[$];
  logic [31:0]                    exp_rd_addr[$];
  logic [31:0]                    exp_wr_addr[$];
  logic [LB-1:0]                  exp_wr_line[$];
  int                             credit_cycles[$];

  logic [31:0] lcg_state;
  int          cycle_count;
  int          credits;
  int          issued;
  int          credit_count;
  int          rsp_count;
  int          hit_count;
  logic        mem_busy;
  int          mem_wait;

  dcache_top dcache_top_inst (
    .cs          (cs),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .i_req_write (i_req_write),
    .i_req_size  (i_req_size),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .o_credit    (o_credit),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_hit   (o_rsp_hit),
    .o_rsp_rdata (o_rsp_rdata),
    .o_mem_addr  (o_mem_addr),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_rdata (i_mem_rdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_done  (i_mem_done)
  );

  always #5 cs = ~cs;

  always @(posedge cs) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: %0d of %0d responses after %0d cycles", rsp_count, NUM_REQS,
               cycle_count);
      $display("Test failures found");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned lcg_below(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 16) % n;
  endfunction

  // Initial memory content, mixes every address bit
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24] ^ h[15:8];
  endfunction

  function automatic logic [LB-1:0] ref_line(input logic [31:0] line_addr);
    logic [LB-1:0] line;
    int            off;
    off = int'(line_addr - BASE_ADDR);
    for (int k = 0; k < LB / 8; k++) begin
      line[k*8 +: 8] = ref_mem[off + k];
    end
    return line;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_idle_outputs(input string when);
    assert (o_rsp_valid === 1'b0 && o_credit === 1'b0 && o_mem_rd === 1'b0 &&
            o_mem_wr === 1'b0)
      else abort_run($sformatf(
        "[FAIL] outputs %s: o_rsp_valid=%h o_credit=%h o_mem_rd=%h o_mem_wr=%h",
        when, o_rsp_valid, o_credit, o_mem_rd, o_mem_wr));
  endtask

  task automatic check_credit();
    if (o_credit !== 1'b1) return;
    assert (credit_count < issued) else abort_run("Credit returned with no request queued");
    credit_count++;
    credits++;
    credit_cycles.push_back(cycle_count);
    assert (credits <= access_pkg::REQ_CREDITS)
      else abort_run($sformatf("[FAIL] credits: held %h, limit %h", credits,
                               access_pkg::REQ_CREDITS));
  endtask

  task automatic check_response();
    logic        hit_e;
    logic        write_e;
    logic        first_e;
    logic [31:0] rdata_e;
    int          c;
    if (o_rsp_valid !== 1'b1) return;
    assert (exp_hit.size() > 0) else abort_run("Response pulse with no request outstanding");
    assert (credit_cycles.size() > 0) else abort_run("Response came before its credit");
    hit_e   = exp_hit.pop_front();
    write_e = exp_write.pop_front();
    first_e = exp_first.pop_front();
    rdata_e = exp_rdata.pop_front();
    c       = credit_cycles.pop_front();
    assert (!(first_e && o_rsp_hit)) else abort_run("First access to a set after reset hit");
    assert (o_rsp_hit === hit_e)
      else abort_run($sformatf("[FAIL] o_rsp_hit: got %h expected %h", o_rsp_hit, hit_e));
    assert (o_rsp_rdata === rdata_e)
      else abort_run($sformatf("[FAIL] o_rsp_rdata: got %h expected %h", o_rsp_rdata, rdata_e));
    // Store hits still wait for the line write
    if (hit_e && !write_e) begin
      assert (cycle_count == c + 2)
        else abort_run($sformatf("[FAIL] o_rsp_valid: hit at cycle %h expected %h",
                                 cycle_count, c + 2));
    end
    if (hit_e) hit_count++;
    rsp_count++;
  endtask

  // Line memory with a random 0 to 5 cycle answer
  task automatic serve_memory();
    int          off;
    logic [31:0] addr_e;
    logic [LB-1:0] line_e;
    i_mem_ready = 1'b0;
    i_mem_done  = 1'b0;
    if (o_mem_rd !== 1'b1 && o_mem_wr !== 1'b1) return;
    assert (!(o_mem_rd && o_mem_wr)) else abort_run("Line read and write requested together");
    off = int'(o_mem_addr - BASE_ADDR);
    if (!mem_busy) begin
      assert (o_mem_addr >= BASE_ADDR && o_mem_addr < BASE_ADDR + MEM_BYTES)
        else abort_run("Memory access outside the test region");
      if (o_mem_rd) begin
        assert (exp_rd_addr.size() > 0) else abort_run("Line read without a cache miss");
        addr_e = exp_rd_addr.pop_front();
        assert (o_mem_addr === addr_e)
          else abort_run($sformatf("[FAIL] o_mem_addr: got %h expected %h", o_mem_addr, addr_e));
      end else begin
        assert (exp_wr_addr.size() > 0) else abort_run("Line write without a store");
        addr_e = exp_wr_addr.pop_front();
        line_e = exp_wr_line.pop_front();
        assert (o_mem_addr === addr_e)
          else abort_run($sformatf("[FAIL] o_mem_addr: got %h expected %h", o_mem_addr, addr_e));
        assert (o_mem_wdata === line_e)
          else abort_run($sformatf("[FAIL] o_mem_wdata: got %h expected %h", o_mem_wdata, line_e));
      end
      mem_busy = 1'b1;
      mem_wait = lcg_below(6);
    end
    if (mem_wait > 0) begin
      mem_wait--;
      return;
    end
    mem_busy = 1'b0;
    for (int k = 0; k < LB / 8; k++) begin
      if (o_mem_rd) i_mem_rdata[k*8 +: 8] = model_mem[off + k];
      else model_mem[off + k] = o_mem_wdata[k*8 +: 8];
    end
    if (o_mem_rd) i_mem_ready = 1'b1;
    else i_mem_done = 1'b1;
  endtask

  task automatic issue_request();
    logic [31:0]                    addr;
    logic [31:0]                    hi;
    logic [31:0]                    lo;
    logic                           write;
    access_pkg::store_size_e        size;
    logic [cache_pkg::SET_BITS-1:0] set_idx;
    logic [cache_pkg::TAG_BITS-1:0] tag;
    logic                           hit;
    int                             off;
    i_req_valid = 1'b0;
    if (issued >= NUM_REQS || credits == 0 || lcg_below(4) == 0) return;
    write = (lcg_below(2) == 1);
    size  = access_pkg::store_size_e'(lcg_below(3));
    addr  = BASE_ADDR + lcg_below(MEM_BYTES);
    hi    = lcg_next();
    lo    = lcg_next();
    if (write && size == access_pkg::SW) addr[1:0] = 2'b00;
    if (write && size == access_pkg::SH) addr[0] = 1'b0;
    // Direct-mapped: 5 offset bits, 3 set bits, tag above
    off     = int'(addr - BASE_ADDR);
    set_idx = addr[7:5];
    tag     = addr[31:8];
    hit     = ref_valid[set_idx] && (ref_tag[set_idx] == tag);
    exp_first.push_back(!ref_valid[set_idx]);
    exp_hit.push_back(hit);
    exp_write.push_back(write);
    if (!hit) begin
      exp_rd_addr.push_back({addr[31:5], 5'd0});  // Both loads and stores allocate
      ref_valid[set_idx] = 1'b1;
      ref_tag[set_idx]   = tag;
    end
    if (write) begin
      case (size)
        access_pkg::SB: ref_mem[off] = lo[23:16];
        access_pkg::SH: begin
          ref_mem[off]     = lo[23:16];
          ref_mem[off + 1] = lo[31:24];
        end
        default: begin
          for (int k = 0; k < 4; k++) begin
            ref_mem[off + k] = (k < 2) ? lo[16 + k*8 +: 8] : hi[k*8 +: 8];
          end
        end
      endcase
      exp_wr_addr.push_back({addr[31:5], 5'd0});
      exp_wr_line.push_back(ref_line({addr[31:5], 5'd0}));
      exp_rdata.push_back(32'd0);
    end else begin
      off = off & ~3;  // Aligned word
      exp_rdata.push_back({ref_mem[off + 3], ref_mem[off + 2], ref_mem[off + 1], ref_mem[off]});
    end
    i_req_valid = 1'b1;
    i_req_write = write;
    i_req_size  = size;
    i_req_addr  = addr;
    i_req_wdata = {hi[31:16], lo[31:16]};
    credits--;
    issued++;
  endtask

  task automatic step_cycle();
    check_credit();
    check_response();
    serve_memory();
    issue_request();
  endtask

  initial begin
    cs           = 1'b0;
    i_rst_n      = 1'b0;
    i_req_valid  = 1'b0;
    i_req_write  = 1'b0;
    i_req_size   = access_pkg::SW;
    i_req_addr   = 32'd0;
    i_req_wdata  = 32'd0;
    i_mem_rdata  = '0;
    i_mem_ready  = 1'b0;
    i_mem_done   = 1'b0;
    lcg_state    = 32'd74;
    cycle_count  = 0;
    credits      = access_pkg::REQ_CREDITS;
    issued       = 0;
    credit_count = 0;
    rsp_count    = 0;
    hit_count    = 0;
    mem_busy     = 1'b0;
    mem_wait     = 0;
    ref_valid    = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i]   = fill_byte(BASE_ADDR + i);
      model_mem[i] = fill_byte(BASE_ADDR + i);
    end

    repeat (3) begin
      @(posedge cs);
      #1;
      check_idle_outputs("during reset");
    end
    i_rst_n = 1'b1;
    @(posedge cs);
    #1;
    check_idle_outputs("after reset");

    while (rsp_count < NUM_REQS) begin
      @(posedge cs);
      #1;
      step_cycle();
    end
    // Quiet tail, nothing more may come back
    repeat (10) begin
      @(posedge cs);
      #1;
      step_cycle();
    end

    assert (credit_count == NUM_REQS && exp_hit.size() == 0 && exp_rd_addr.size() == 0 &&
            exp_wr_addr.size() == 0)
      else abort_run("Credits, responses or memory accesses left unmatched at the end");
    $display("Requests %0d, hits %0d, cycles %0d", rsp_count, hit_count, cycle_count);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/cache_pkg.sv
src/access_pkg.sv
src/dcache_req_queue.sv
src/dcache_line_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module dcache_tb -o dcache_sim

# tee keeps the run going to the log check even when the simulation stops early
./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q 'Test failures found' sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
